/* common/i2c_pkg.sv */
// bus-level constants for the byte engine and the sequencer
// scl period is 4 * SCL_QTR sys_clk cycles; no clock stretching
// a command is one-hot per action and may combine start, stop and ack
package i2c_pkg;

	// byte command layout
	localparam int CMD_W = 5;

	// bit positions inside a command
	localparam int CMD_START = 0;
	localparam int CMD_WRITE = 1;
	localparam int CMD_READ  = 2;
	localparam int CMD_STOP  = 3;
	// master acks a read byte when set, nacks it otherwise
	localparam int CMD_ACK   = 4;

	// sys_clk cycles per quarter of an scl period
	localparam int SCL_QTR = 4;
	localparam int DIV_W   = (SCL_QTR > 1) ? $clog2(SCL_QTR) : 1;

	typedef logic [CMD_W-1:0] i2c_cmd_t;

endpackage

/* common/adc_pkg.sv */
// converter-level widths, transaction lengths and the read-word layout
// the converter returns an 8-bit code in the middle of the two read bytes,
// and rd_data carries it zero-extended to SAMPLE_W bits
package adc_pkg;

	// addressing fields
	localparam int DEV_ID_W = 7;
	localparam int REG_W    = 8;

	// host-side sample width and the code inside the read word
	localparam int SAMPLE_W = 12;
	localparam int CODE_W   = 8;

	// byte commands per transaction
	localparam int WR_BYTES = 3;
	localparam int RD_BYTES = 5;
	localparam int CNT_W    = $clog2(RD_BYTES);

	// two read bytes, seen as raw bytes or as the padded code
	typedef union packed {
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} raw;
		struct packed {
			logic [3:0]        pad_hi;
			logic [CODE_W-1:0] code;
			logic [3:0]        pad_lo;
		} smp;
	} adc_word_u;

endpackage

/* hw/adc_req_capture.sv */
// host request front end
// address fields latch on reg_addr_vld, write data on wr_data_vld
// requests while busy are dropped; a write wins over a simultaneous read
module adc_req_capture (
	input  logic                          sys_clk,
	input  logic                          sys_rst_n,
	input  logic                          wr_req,
	input  logic                          rd_req,
	input  logic [adc_pkg::DEV_ID_W-1:0]  device_id,
	input  logic [adc_pkg::REG_W-1:0]     reg_addr,
	input  logic                          reg_addr_vld,
	input  logic [7:0]                    wr_data,
	input  logic                          wr_data_vld,
	input  logic                          ready,
	output logic                          start_wr,
	output logic                          start_rd,
	output logic [adc_pkg::DEV_ID_W-1:0]  dev_id_q,
	output logic [adc_pkg::REG_W-1:0]     reg_q,
	output logic [7:0]                    wr_q
);
	import adc_pkg::*;

	logic accept;

	// ready only falls a cycle after the start pulse, so block that cycle too
	assign accept = ready & ~start_wr & ~start_rd;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			start_wr <= 1'b0;
			start_rd <= 1'b0;
		end else begin
			start_wr <= accept & wr_req;
			start_rd <= accept & rd_req & ~wr_req;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reg_addr_vld) begin
			dev_id_q <= device_id;
			reg_q    <= reg_addr;
		end
		if (wr_data_vld)
			wr_q <= wr_data;
	end

endmodule

/* hw/adc_seq.sv */
// transaction sequencer, one byte command at a time to the engine
// write: addr+w, reg, data+stop; read: addr+w, reg, restart addr+r, 2 bytes
// a nack on any written byte ends the transaction with a lone stop
module adc_seq (
	input  logic                          sys_clk,
	input  logic                          sys_rst_n,
	input  logic                          start_wr,
	input  logic                          start_rd,
	input  logic [adc_pkg::DEV_ID_W-1:0]  dev_id_q,
	input  logic [adc_pkg::REG_W-1:0]     reg_q,
	input  logic [7:0]                    wr_q,
	input  logic                          byte_done,
	input  logic                          nack,
	input  logic [7:0]                    rd_byte,
	output i2c_pkg::i2c_cmd_t             cmd,
	output logic                          cmd_vld,
	output logic [7:0]                    tx_byte,
	output logic [7:0]                    rx_byte,
	output logic                          rx_hi,
	output logic                          rx_vld,
	output logic                          ready,
	output logic                          ack_err
);
	import i2c_pkg::*;
	import adc_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WRITE,
		S_READ,
		S_ABORT,
		S_FINISH
	} seq_state_t;

	seq_state_t       state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] step;
	logic [CNT_W-1:0] last_step;
	logic             rd_path;
	logic             rx_take;
	i2c_cmd_t         cmd_sel;
	logic [7:0]       tx_sel;

	// step about to be issued and the kind of transaction it belongs to
	assign step      = (state == S_IDLE) ? '0 : cnt + 1'b1;
	assign rd_path   = (state == S_READ);
	assign last_step = rd_path ? CNT_W'(RD_BYTES - 1) : CNT_W'(WR_BYTES - 1);

	// the last two read steps carry converter data
	assign rx_take = (state == S_READ) & byte_done & ~nack & (cnt >= CNT_W'(RD_BYTES - 2));

	always_comb begin
		cmd_sel  = '0;
		tx_sel   = '0;
		case (step)
			CNT_W'(0): begin
				cmd_sel[CMD_START] = 1'b1;
				cmd_sel[CMD_WRITE] = 1'b1;
				tx_sel = {dev_id_q, 1'b0};
			end
			CNT_W'(1): begin
				cmd_sel[CMD_WRITE] = 1'b1;
				tx_sel = reg_q;
			end
			CNT_W'(2): begin
				cmd_sel[CMD_WRITE] = 1'b1;
				if (rd_path) begin
					// repeated start with the read address
					cmd_sel[CMD_START] = 1'b1;
					tx_sel = {dev_id_q, 1'b1};
				end else begin
					cmd_sel[CMD_STOP] = 1'b1;
					tx_sel = wr_q;
				end
			end
			CNT_W'(3): begin
				cmd_sel[CMD_READ] = 1'b1;
				cmd_sel[CMD_ACK]  = 1'b1;
			end
			default: begin
				cmd_sel[CMD_READ] = 1'b1;
				cmd_sel[CMD_STOP] = 1'b1;
			end
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= S_IDLE;
			cnt     <= '0;
			cmd     <= '0;
			cmd_vld <= 1'b0;
			tx_byte <= '0;
			ready   <= 1'b1;
			ack_err <= 1'b0;
			rx_vld  <= 1'b0;
		end else begin
			cmd_vld <= 1'b0;
			rx_vld  <= rx_take;
			case (state)
				S_IDLE: begin
					if (start_wr || start_rd) begin
						state   <= start_wr ? S_WRITE : S_READ;
						ready   <= 1'b0;
						ack_err <= 1'b0;
						cnt     <= '0;
						cmd     <= cmd_sel;
						tx_byte <= tx_sel;
						cmd_vld <= 1'b1;
					end
				end
				S_WRITE, S_READ: begin
					if (byte_done) begin
						if (nack) begin
							state   <= S_ABORT;
							ack_err <= 1'b1;
							cmd     <= i2c_cmd_t'(1 << CMD_STOP);
							tx_byte <= '0;
							cmd_vld <= 1'b1;
						end else if (cnt == last_step) begin
							state <= S_FINISH;
						end else begin
							cnt     <= step;
							cmd     <= cmd_sel;
							tx_byte <= tx_sel;
							cmd_vld <= 1'b1;
						end
					end
				end
				S_ABORT: begin
					if (byte_done)
						state <= S_FINISH;
				end
				default: begin
					// one cycle here lines ready up with rd_data_vld
					ready <= 1'b1;
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_take) begin
			rx_byte <= rd_byte;
			rx_hi   <= (cnt == CNT_W'(RD_BYTES - 1));
		end
	end

endmodule

/* i2c/i2c_byte_engine.sv */
// bit-level I2C master, one byte per command
// each phase (start, data bit, stop) is four quarters of SCL_QTR cycles
// sda is open drain; a written byte's missing ack skips the stop and raises nack
module i2c_byte_engine (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  i2c_pkg::i2c_cmd_t cmd,
	input  logic              cmd_vld,
	input  logic [7:0]        tx_byte,
	output logic [7:0]        rd_byte,
	output logic              byte_done,
	output logic              nack,
	output logic              scl,
	inout  wire               sda
);
	import i2c_pkg::*;

	typedef enum logic [1:0] {
		E_IDLE,
		E_START,
		E_DATA,
		E_STOP
	} phase_t;

	phase_t           phase;
	phase_t           nxt_phase;
	phase_t           first_phase;
	i2c_cmd_t         cmd_q;
	logic [DIV_W-1:0] div;
	logic [1:0]       qtr;
	logic [3:0]       bit_cnt;
	logic [7:0]       tx_sh;
	logic             ack_miss;
	logic             sda_oe;
	logic             qtr_end;
	logic             phase_end;
	logic             last_bit;
	logic             sample;
	logic             scl_nxt;
	logic             sda_oe_nxt;

	assign sda = sda_oe ? 1'b0 : 1'bz;

	assign qtr_end   = (div == DIV_W'(SCL_QTR - 1));
	assign phase_end = qtr_end && (qtr == 2'd3);
	// bit 8 is the acknowledge slot
	assign last_bit  = (bit_cnt == 4'd8);
	// middle of the scl high time
	assign sample    = (phase == E_DATA) && (qtr == 2'd2) && (div == '0);

	// first phase of a freshly accepted command
	always_comb begin
		if (cmd[CMD_START])
			first_phase = E_START;
		else if (cmd[CMD_WRITE] || cmd[CMD_READ])
			first_phase = E_DATA;
		else if (cmd[CMD_STOP])
			first_phase = E_STOP;
		else
			first_phase = E_IDLE;
	end

	// phase that follows the current one
	always_comb begin
		nxt_phase = E_IDLE;
		case (phase)
			E_START: begin
				if (cmd_q[CMD_WRITE] || cmd_q[CMD_READ])
					nxt_phase = E_DATA;
				else if (cmd_q[CMD_STOP])
					nxt_phase = E_STOP;
			end
			E_DATA: begin
				if (!last_bit)
					nxt_phase = E_DATA;
				else if (cmd_q[CMD_STOP] && !ack_miss)
					nxt_phase = E_STOP;
			end
			default: nxt_phase = E_IDLE;
		endcase
	end

	// line levels per quarter; idle keeps the bus where the last byte left it
	always_comb begin
		scl_nxt    = scl;
		sda_oe_nxt = sda_oe;
		case (phase)
			E_START: begin
				scl_nxt    = (qtr == 2'd1) || (qtr == 2'd2);
				sda_oe_nxt = qtr[1];
			end
			E_DATA: begin
				scl_nxt = (qtr == 2'd1) || (qtr == 2'd2);
				if (!last_bit)
					sda_oe_nxt = cmd_q[CMD_WRITE] & ~tx_sh[7];
				else
					sda_oe_nxt = cmd_q[CMD_READ] & cmd_q[CMD_ACK];
			end
			E_STOP: begin
				scl_nxt    = (qtr != 2'd0);
				sda_oe_nxt = ~qtr[1];
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			phase     <= E_IDLE;
			cmd_q     <= '0;
			div       <= '0;
			qtr       <= 2'd0;
			bit_cnt   <= 4'd0;
			ack_miss  <= 1'b0;
			byte_done <= 1'b0;
			nack      <= 1'b0;
			scl       <= 1'b1;
			sda_oe    <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			nack      <= 1'b0;
			scl       <= scl_nxt;
			sda_oe    <= sda_oe_nxt;
			if (phase == E_IDLE) begin
				if (cmd_vld) begin
					phase    <= first_phase;
					cmd_q    <= cmd;
					div      <= '0;
					qtr      <= 2'd0;
					bit_cnt  <= 4'd0;
					ack_miss <= 1'b0;
					// an empty command completes at once
					byte_done <= (first_phase == E_IDLE);
				end
			end else begin
				div <= qtr_end ? '0 : div + 1'b1;
				if (qtr_end)
					qtr <= qtr + 2'd1;
				if (sample && last_bit && cmd_q[CMD_WRITE])
					ack_miss <= sda;
				if (phase_end) begin
					phase <= nxt_phase;
					if (phase == E_DATA && !last_bit)
						bit_cnt <= bit_cnt + 4'd1;
					if (nxt_phase == E_IDLE) begin
						byte_done <= 1'b1;
						nack      <= ack_miss;
					end
				end
			end
		end
	end

	// data shifters, msb first
	always_ff @(posedge sys_clk) begin
		if (phase == E_IDLE && cmd_vld)
			tx_sh <= tx_byte;
		else if (phase == E_DATA && phase_end)
			tx_sh <= {tx_sh[6:0], 1'b0};
		if (sample && !last_bit)
			rd_byte <= {rd_byte[6:0], sda};
	end

endmodule

/* hw/adc_sample_out.sv */
// read data output stage
// low byte arrives first and is held; the high byte completes the word
// rd_data holds its value until the next completed read
module adc_sample_out (
	input  logic                          sys_clk,
	input  logic                          sys_rst_n,
	input  logic [7:0]                    rx_byte,
	input  logic                          rx_hi,
	input  logic                          rx_vld,
	output logic [adc_pkg::SAMPLE_W-1:0]  rd_data,
	output logic                          rd_data_vld
);
	import adc_pkg::*;

	logic [7:0] lo_q;
	adc_word_u  word;

	// incoming high byte joins the stored low byte
	always_comb begin
		word.raw.hi = rx_byte;
		word.raw.lo = lo_q;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rd_data_vld <= 1'b0;
		else
			rd_data_vld <= rx_vld & rx_hi;
	end

	always_ff @(posedge sys_clk) begin
		if (rx_vld && !rx_hi)
			lo_q <= rx_byte;
		if (rx_vld && rx_hi)
			rd_data <= SAMPLE_W'(word.smp.code);
	end

endmodule

/* hw/adc_i2c_top.sv */
// I2C ADC controller top
// sda needs an external pull-up; scl is driven push-pull
module adc_i2c_top (
	input  logic                          sys_clk,
	input  logic                          sys_rst_n,
	input  logic                          wr_req,
	input  logic                          rd_req,
	input  logic [adc_pkg::DEV_ID_W-1:0]  device_id,
	input  logic [adc_pkg::REG_W-1:0]     reg_addr,
	input  logic                          reg_addr_vld,
	input  logic [7:0]                    wr_data,
	input  logic                          wr_data_vld,
	output logic [adc_pkg::SAMPLE_W-1:0]  rd_data,
	output logic                          rd_data_vld,
	output logic                          ready,
	output logic                          ack_err,
	output logic                          scl,
	inout  wire                           sda
);
	import adc_pkg::*;
	import i2c_pkg::*;

	logic                start_wr;
	logic                start_rd;
	logic [DEV_ID_W-1:0] dev_id_q;
	logic [REG_W-1:0]    reg_q;
	logic [7:0]          wr_q;
	i2c_cmd_t            cmd;
	logic                cmd_vld;
	logic [7:0]          tx_byte;
	logic [7:0]          rd_byte;
	logic                byte_done;
	logic                nack;
	logic [7:0]          rx_byte;
	logic                rx_hi;
	logic                rx_vld;

	adc_req_capture u_req_capture (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.wr_req(wr_req), .rd_req(rd_req),
		.device_id(device_id), .reg_addr(reg_addr), .reg_addr_vld(reg_addr_vld),
		.wr_data(wr_data), .wr_data_vld(wr_data_vld), .ready(ready),
		.start_wr(start_wr), .start_rd(start_rd),
		.dev_id_q(dev_id_q), .reg_q(reg_q), .wr_q(wr_q)
	);

	adc_seq u_seq (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.start_wr(start_wr), .start_rd(start_rd),
		.dev_id_q(dev_id_q), .reg_q(reg_q), .wr_q(wr_q),
		.byte_done(byte_done), .nack(nack), .rd_byte(rd_byte),
		.cmd(cmd), .cmd_vld(cmd_vld), .tx_byte(tx_byte),
		.rx_byte(rx_byte), .rx_hi(rx_hi), .rx_vld(rx_vld),
		.ready(ready), .ack_err(ack_err)
	);

	i2c_byte_engine u_byte_engine (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cmd(cmd), .cmd_vld(cmd_vld), .tx_byte(tx_byte),
		.rd_byte(rd_byte), .byte_done(byte_done), .nack(nack),
		.scl(scl), .sda(sda)
	);

	adc_sample_out u_sample_out (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.rx_byte(rx_byte), .rx_hi(rx_hi), .rx_vld(rx_vld),
		.rd_data(rd_data), .rd_data_vld(rd_data_vld)
	);

endmodule

/* testbench/adc_i2c_assert.sv */
// bus protocol checks, bound to adc_i2c_top
// failures raise $error and bump fail_cnt for the testbench to pick up
module adc_i2c_assert (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic ready,
	input logic scl,
	input logic rd_data_vld
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;

	// valid is a single-cycle pulse
	a_vld_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rd_data_vld |=> !rd_data_vld)
	else begin
		$error("rd_data_vld stayed high for more than one cycle");
		fail_cnt++;
	end

	// scl only moves during a transaction
	a_busy_scl: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$changed(scl) |-> !ready)
	else begin
		$error("scl toggled while ready was high");
		fail_cnt++;
	end

	// bus left free when idle
	a_idle_scl: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		ready |-> scl)
	else begin
		$error("scl low while ready was high");
		fail_cnt++;
	end

endmodule

bind adc_i2c_top adc_i2c_assert u_assert (
	.sys_clk(sys_clk),
	.sys_rst_n(sys_rst_n),
	.ready(ready),
	.scl(scl),
	.rd_data_vld(rd_data_vld)
);

/* testbench/i2c_slave_model.sv */
// behavioral I2C converter slave, 7-bit address, no clock stretching
// write: reg byte then data byte stored per register
// read: returns stored byte first, then the register address
module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h48
) (
	input logic scl,
	inout wire  sda
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum {P_ADDR, P_REG, P_DATA, P_READ, P_IGNORE} slv_phase_t;

	logic [7:0] mem [0:255];
	logic [7:0] sh;
	logic [7:0] tx;
	logic [7:0] reg_ptr;
	logic       in_frame;
	logic       drive_low;
	slv_phase_t ph;
	int         bit_cnt;
	int         rd_idx;
	int         start_cnt;
	int         wr_cnt;

	assign sda = drive_low ? 1'b0 : 1'bz;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = i[7:0] ^ 8'ha5;
		in_frame  = 1'b0;
		drive_low = 1'b0;
		reg_ptr   = '0;
		bit_cnt   = 0;
		rd_idx    = 0;
		start_cnt = 0;
		wr_cnt    = 0;
		ph        = P_IGNORE;
	end

	// start or repeated start
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			in_frame  = 1'b1;
			ph        = P_ADDR;
			bit_cnt   = 0;
			drive_low = 1'b0;
			start_cnt++;
		end
	end

	// stop
	always @(posedge sda) begin
		if (scl === 1'b1) begin
			in_frame  = 1'b0;
			drive_low = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (in_frame) begin
			if (bit_cnt < 8)
				sh = {sh[6:0], sda};
			bit_cnt++;
		end
	end

	always @(negedge scl) begin
		if (in_frame) begin
			if (bit_cnt == 8) begin
				drive_low = 1'b0;
				case (ph)
					P_ADDR: begin
						if (sh[7:1] == DEV_ADDR) begin
							drive_low = 1'b1;
							ph = sh[0] ? P_READ : P_REG;
							rd_idx = 0;
						end else begin
							ph = P_IGNORE;
						end
					end
					P_REG: begin
						reg_ptr   = sh;
						drive_low = 1'b1;
						ph        = P_DATA;
					end
					P_DATA: begin
						mem[reg_ptr] = sh;
						wr_cnt++;
						drive_low = 1'b1;
					end
					default: ;
				endcase
			end else if (bit_cnt == 9) begin
				bit_cnt   = 0;
				drive_low = 1'b0;
				// only two bytes per read
				if (ph == P_READ && rd_idx < 2) begin
					tx = (rd_idx == 0) ? mem[reg_ptr] : reg_ptr;
					rd_idx++;
					drive_low = ~tx[7];
				end
			end else if (ph == P_READ && rd_idx > 0) begin
				drive_low = ~tx[7 - bit_cnt];
			end
		end
	end

endmodule

/* testbench/tb_adc_i2c.sv */
// testbench for adc_i2c_top with a behavioral converter on the bus
// expected read value: reg low nibble then stored byte high nibble, zero-extended
module tb_adc_i2c;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [6:0] SLV_ADDR = 7'b1001_000;

	logic        sys_clk;
	logic        sys_rst_n;
	logic        wr_req;
	logic        rd_req;
	logic [6:0]  device_id;
	logic [7:0]  reg_addr;
	logic        reg_addr_vld;
	logic [7:0]  wr_data;
	logic        wr_data_vld;
	logic [11:0] rd_data;
	logic        rd_data_vld;
	logic        ready;
	logic        ack_err;
	logic        scl;
	wire         sda;

	integer      seed;
	logic [31:0] rnd;
	logic [7:0]  regs [4];
	logic [7:0]  vals [4];
	logic [7:0]  d;
	logic [11:0] last_rd;
	int          vld_cnt;
	int          wr_base;
	int          st_base;

	adc_i2c_top UUT (.*);

	pullup (sda);

	i2c_slave_model #(.DEV_ADDR(SLV_ADDR)) u_slave (.scl(scl), .sda(sda));

	always #4 sys_clk = ~sys_clk;

	function automatic logic [11:0] expected_sample(input logic [7:0] r, input logic [7:0] data);
		return {4'h0, r[3:0], data[7:4]};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act)
			abort_run($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
	endtask

	// protocol assertions stop the run at once
	always @(negedge sys_clk) begin
		if (UUT.u_assert.fail_cnt != 0)
			abort_run("a bus protocol assertion failed");
	end

	task automatic send_request(input logic [6:0] dev, input logic [7:0] r,
		input logic [7:0] data, input logic wr, input logic rd);
		// write data strobed a cycle ahead of the address and the request
		@(posedge sys_clk);
		#1;
		wr_data     = data;
		wr_data_vld = wr;
		@(posedge sys_clk);
		#1;
		wr_data      = ~data;
		wr_data_vld  = 1'b0;
		device_id    = dev;
		reg_addr     = r;
		reg_addr_vld = 1'b1;
		wr_req       = wr;
		rd_req       = rd;
		@(posedge sys_clk);
		#1;
		reg_addr_vld = 1'b0;
		wr_req       = 1'b0;
		rd_req       = 1'b0;
	endtask

	task automatic wait_busy();
		int n;
		n = 0;
		while (ready !== 1'b0) begin
			@(negedge sys_clk);
			n++;
			if (n > 20)
				abort_run("timeout: ready did not fall after a request");
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		vld_cnt = 0;
		while (ready !== 1'b1) begin
			@(negedge sys_clk);
			n++;
			if (rd_data_vld === 1'b1) begin
				vld_cnt++;
				last_rd = rd_data;
			end
			if (n > 5000)
				abort_run("timeout: ready did not return high");
		end
	endtask

	task automatic do_write(input logic [7:0] r, input logic [7:0] data);
		send_request(SLV_ADDR, r, data, 1'b1, 1'b0);
		wait_busy();
		wait_idle();
		check_val("write ack_err", 16'h0, {15'h0, ack_err});
	endtask

	task automatic do_read(input string name, input logic [7:0] r, input logic [11:0] exp);
		send_request(SLV_ADDR, r, 8'h00, 1'b0, 1'b1);
		wait_busy();
		wait_idle();
		check_val({name, " valid count"}, 16'd1, 16'(vld_cnt));
		check_val(name, {4'h0, exp}, {4'h0, last_rd});
		check_val({name, " ack_err"}, 16'h0, {15'h0, ack_err});
	endtask

	initial begin
		seed = 32'hf49f_728c;
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		wr_req = 1'b0;
		rd_req = 1'b0;
		device_id = '0;
		reg_addr = '0;
		reg_addr_vld = 1'b0;
		wr_data = '0;
		wr_data_vld = 1'b0;
		regs = '{8'h13, 8'h27, 8'h5c, 8'h9e};
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;

		// reset state
		@(negedge sys_clk);
		check_val("reset ready", 16'h1, {15'h0, ready});
		check_val("reset rd_data_vld", 16'h0, {15'h0, rd_data_vld});
		check_val("reset ack_err", 16'h0, {15'h0, ack_err});
		check_val("reset scl", 16'h1, {15'h0, scl});

		// write then read back
		rnd = $random(seed);
		d = rnd[7:0];
		do_write(8'h40, d);
		do_read("readback 0x40", 8'h40, expected_sample(8'h40, d));

		// separate registers, separate data
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			vals[i] = rnd[7:0];
			do_write(regs[i], vals[i]);
		end
		for (int i = 0; i < 4; i++)
			do_read($sformatf("multi reg %h", regs[i]), regs[i],
				expected_sample(regs[i], vals[i]));

		// wrong device address ends after the first byte
		st_base = u_slave.start_cnt;
		send_request(7'h2a, 8'h40, 8'h00, 1'b0, 1'b1);
		wait_busy();
		wait_idle();
		check_val("bad id ack_err", 16'h1, {15'h0, ack_err});
		check_val("bad id valid count", 16'h0, 16'(vld_cnt));
		check_val("bad id starts", 16'(st_base + 1), 16'(u_slave.start_cnt));

		// requests while busy are dropped
		rnd = $random(seed);
		d = rnd[7:0];
		wr_base = u_slave.wr_cnt;
		st_base = u_slave.start_cnt;
		send_request(SLV_ADDR, 8'h61, d, 1'b1, 1'b0);
		wait_busy();
		@(posedge sys_clk);
		#1;
		wr_req = 1'b1;
		rd_req = 1'b1;
		@(posedge sys_clk);
		#1;
		wr_req = 1'b0;
		rd_req = 1'b0;
		wait_idle();
		repeat (10) @(negedge sys_clk);
		check_val("busy drop ready", 16'h1, {15'h0, ready});
		check_val("busy drop writes", 16'(wr_base + 1), 16'(u_slave.wr_cnt));
		check_val("busy drop starts", 16'(st_base + 1), 16'(u_slave.start_cnt));
		do_read("busy drop readback", 8'h61, expected_sample(8'h61, d));

		// write wins over a simultaneous read
		rnd = $random(seed);
		d = rnd[7:0];
		wr_base = u_slave.wr_cnt;
		st_base = u_slave.start_cnt;
		send_request(SLV_ADDR, 8'h72, d, 1'b1, 1'b1);
		wait_busy();
		wait_idle();
		check_val("priority valid count", 16'h0, 16'(vld_cnt));
		check_val("priority writes", 16'(wr_base + 1), 16'(u_slave.wr_cnt));
		check_val("priority starts", 16'(st_base + 1), 16'(u_slave.start_cnt));
		do_read("priority readback", 8'h72, expected_sample(8'h72, d));

		repeat (4) @(negedge sys_clk);
		if (UUT.u_assert.fail_cnt == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "errors were found");
		end
	end

endmodule

/* tb.f */
common/i2c_pkg.sv
common/adc_pkg.sv
hw/adc_req_capture.sv
hw/adc_seq.sv
i2c/i2c_byte_engine.sv
hw/adc_sample_out.sv
hw/adc_i2c_top.sv
testbench/adc_i2c_assert.sv
testbench/i2c_slave_model.sv
testbench/tb_adc_i2c.sv
